// ==== src/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    ////////////////////////////////////////
    // Character format
    ////////////////////////////////////////

    // 8N1, LSB first on the line
    localparam int DATA_BITS    = 8;
    localparam int BIT_CNT_BITS = $clog2(DATA_BITS);

    localparam logic [BIT_CNT_BITS-1:0] LAST_BIT = BIT_CNT_BITS'(DATA_BITS - 1);

    // Bit period in clocks, short to keep simulation fast
    localparam int CLKS_PER_BIT  = 16;
    localparam int HALF_BIT      = CLKS_PER_BIT / 2;
    localparam int BAUD_CNT_BITS = $clog2(CLKS_PER_BIT);

    localparam logic [BAUD_CNT_BITS-1:0] BAUD_LAST = BAUD_CNT_BITS'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_BITS-1:0] HALF_LAST = BAUD_CNT_BITS'(HALF_BIT - 1);

    ////////////////////////////////////////
    // Buffering
    ////////////////////////////////////////

    // Power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);

    ////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        TX_IDLE  = 3'b000,
        TX_START = 3'b001,
        TX_DATA  = 3'b010,
        TX_STOP  = 3'b011,
        TX_WAIT  = 3'b100
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,
        RX_START = 2'b01,
        RX_DATA  = 2'b10,
        RX_STOP  = 2'b11
    } rx_state_e;

endpackage

`default_nettype wire

// ==== src/axis_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Byte stream with valid/ready handshake
interface axis_if #(
    parameter int WIDTH = uart_pkg::DATA_BITS
) (
    input logic s_axis,
    input logic reset_i
);

    logic [WIDTH-1:0] tdata;
    logic             tvalid;
    logic             tready;

    modport source (
        input  s_axis,
        input  reset_i,
        output tdata,
        output tvalid,
        input  tready
    );

    modport sink (
        input  s_axis,
        input  reset_i,
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

`default_nettype wire

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int WIDTH = uart_pkg::DATA_BITS
) (
    input  logic             s_axis,
    input  logic             reset_i,

    input  logic [WIDTH-1:0] wr_data_i,
    input  logic             wr_valid_i,
    output logic             wr_ready_o,

    output logic [WIDTH-1:0] rd_data_o,
    output logic             rd_valid_o,
    input  logic             rd_ready_i
);

    logic [WIDTH-1:0] mem [uart_pkg::FIFO_DEPTH];

    // One extra bit tells full from empty
    logic [uart_pkg::FIFO_ADDR_BITS:0] wr_ptr;
    logic [uart_pkg::FIFO_ADDR_BITS:0] rd_ptr;
    logic [uart_pkg::FIFO_ADDR_BITS:0] level;

    logic empty;
    logic full;
    logic do_write;
    logic do_read;

    assign level = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = level[uart_pkg::FIFO_ADDR_BITS];

    assign wr_ready_o = ~full;
    assign rd_valid_o = ~empty;

    assign do_write = wr_valid_i & wr_ready_o;
    assign do_read  = rd_valid_o & rd_ready_i;

    // Head entry is shown without a read latency
    assign rd_data_o = mem[rd_ptr[uart_pkg::FIFO_ADDR_BITS-1:0]];

    always_ff @(posedge s_axis) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge s_axis) begin
        if (do_write) begin
            mem[wr_ptr[uart_pkg::FIFO_ADDR_BITS-1:0]] <= wr_data_i;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_level_bound: assert property (
        @(posedge s_axis) disable iff (reset_i)
        int'(level) <= uart_pkg::FIFO_DEPTH
    ) else $error("stream_fifo: level %0d above depth", level);

    // Read pointer must not move out of an empty buffer
    a_no_read_empty: assert property (
        @(posedge s_axis) disable iff (reset_i)
        empty |=> (rd_ptr == $past(rd_ptr))
    ) else $error("stream_fifo: read while empty");

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    output logic uart_tx_o,

    axis_if.sink s_axis_if
);

    uart_pkg::tx_state_e state;

    logic [uart_pkg::BIT_CNT_BITS-1:0]  bit_cnt;
    logic [uart_pkg::BAUD_CNT_BITS-1:0] baud_cnt;
    logic [uart_pkg::DATA_BITS-1:0]     tx_data;

    logic handshake;
    logic baud_done;
    logic bit_done;
    logic in_frame;

    assign s_axis_if.tready = (state == uart_pkg::TX_IDLE);
    assign handshake        = s_axis_if.tvalid & s_axis_if.tready;

    assign baud_done = (baud_cnt == uart_pkg::BAUD_LAST);
    assign bit_done  = (bit_cnt == uart_pkg::LAST_BIT);
    assign in_frame  = (state == uart_pkg::TX_START) ||
                       (state == uart_pkg::TX_DATA)  ||
                       (state == uart_pkg::TX_STOP);

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge s_axis_if.s_axis) begin
        if (s_axis_if.reset_i) begin
            state     <= uart_pkg::TX_IDLE;
            uart_tx_o <= 1'b1;
            bit_cnt   <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    uart_tx_o <= 1'b1;
                    if (handshake) begin
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    uart_tx_o <= 1'b0;
                    if (baud_done) begin
                        state <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    uart_tx_o <= tx_data[bit_cnt];
                    if (baud_done) begin
                        if (bit_done) begin
                            state   <= uart_pkg::TX_STOP;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    uart_tx_o <= 1'b1;
                    if (baud_done) begin
                        state <= uart_pkg::TX_WAIT;
                    end
                end
                // One guard cycle before the next byte
                uart_pkg::TX_WAIT: begin
                    state <= uart_pkg::TX_IDLE;
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Bit period timer, runs only inside a frame
    always_ff @(posedge s_axis_if.s_axis) begin
        if (s_axis_if.reset_i) begin
            baud_cnt <= '0;
        end else if (baud_done) begin
            baud_cnt <= '0;
        end else if (in_frame) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge s_axis_if.s_axis) begin
        if (handshake) begin
            tx_data <= s_axis_if.tdata;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_idle_line_high: assert property (
        @(posedge s_axis_if.s_axis) disable iff (s_axis_if.reset_i)
        (state == uart_pkg::TX_IDLE) |-> uart_tx_o
    ) else $error("uart_tx: line low while idle");

    a_start_on_transfer: assert property (
        @(posedge s_axis_if.s_axis) disable iff (s_axis_if.reset_i)
        (state == uart_pkg::TX_IDLE) && !handshake |=> (state == uart_pkg::TX_IDLE)
    ) else $error("uart_tx: left idle without a transfer");

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic     uart_rx_i,

    axis_if.source   m_axis_if,

    output logic     overrun_o
);

    uart_pkg::rx_state_e state;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    logic [uart_pkg::BAUD_CNT_BITS-1:0] baud_cnt;
    logic [uart_pkg::BIT_CNT_BITS-1:0]  bit_cnt;
    logic [uart_pkg::DATA_BITS-1:0]     shift_reg;
    logic [uart_pkg::DATA_BITS:0]       word;
    logic                               word_valid;

    logic start_edge;
    logic half_done;
    logic baud_done;
    logic bit_done;
    logic sample_data;
    logic sample_stop;

    // Two-flop synchronizer plus one for edge detection, idle line is high
    always_ff @(posedge m_axis_if.s_axis) begin
        if (m_axis_if.reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge  = rx_prev & ~rx_sync;
    assign half_done   = (baud_cnt == uart_pkg::HALF_LAST);
    assign baud_done   = (baud_cnt == uart_pkg::BAUD_LAST);
    assign bit_done    = (bit_cnt == uart_pkg::LAST_BIT);
    assign sample_data = (state == uart_pkg::RX_DATA) && baud_done;
    assign sample_stop = (state == uart_pkg::RX_STOP) && baud_done;

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge m_axis_if.s_axis) begin
        if (m_axis_if.reset_i) begin
            state      <= uart_pkg::RX_IDLE;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            baud_cnt   <= baud_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (start_edge) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                // Recheck the line at the middle of the start bit
                uart_pkg::RX_START: begin
                    if (half_done) begin
                        baud_cnt <= '0;
                        state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (baud_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_done) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (baud_done) begin
                        word_valid <= 1'b1;
                        state      <= uart_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge m_axis_if.s_axis) begin
        if (sample_data) begin
            shift_reg <= {rx_sync, shift_reg[uart_pkg::DATA_BITS-1:1]};
        end
        if (sample_stop) begin
            word <= {~rx_sync, shift_reg};
        end
    end

    assign m_axis_if.tdata  = word;
    assign m_axis_if.tvalid = word_valid;

    // Word is offered once, a full FIFO loses it
    always_ff @(posedge m_axis_if.s_axis) begin
        if (m_axis_if.reset_i) begin
            overrun_o <= 1'b0;
        end else if (word_valid && !m_axis_if.tready) begin
            overrun_o <= 1'b1;
        end
    end

    a_single_pulse: assert property (
        @(posedge m_axis_if.s_axis) disable iff (m_axis_if.reset_i)
        word_valid |=> !word_valid
    ) else $error("uart_rx: tvalid held past one cycle");

endmodule

`default_nettype wire

// ==== src/uart_stream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_stream_top (
    input  logic                          s_axis,
    input  logic                          reset_i,

    // Byte stream into the transmitter
    input  logic [uart_pkg::DATA_BITS-1:0] in_tdata_i,
    input  logic                          in_tvalid_i,
    output logic                          in_tready_o,

    // Serial pins
    output logic                          uart_tx_o,
    input  logic                          uart_rx_i,

    // Received bytes with frame error
    output logic [uart_pkg::DATA_BITS-1:0] out_tdata_o,
    output logic                          out_frame_err_o,
    output logic                          out_tvalid_o,
    input  logic                          out_tready_i,
    output logic                          out_overrun_o
);

    logic [uart_pkg::DATA_BITS:0] rx_word;

    axis_if #(.WIDTH(uart_pkg::DATA_BITS)) tx_stream (
        .s_axis  (s_axis),
        .reset_i (reset_i)
    );

    axis_if #(.WIDTH(uart_pkg::DATA_BITS + 1)) rx_stream (
        .s_axis  (s_axis),
        .reset_i (reset_i)
    );

    ////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////

    stream_fifo #(.WIDTH(uart_pkg::DATA_BITS)) tx_fifo (
        .s_axis     (s_axis),
        .reset_i    (reset_i),
        .wr_data_i  (in_tdata_i),
        .wr_valid_i (in_tvalid_i),
        .wr_ready_o (in_tready_o),
        .rd_data_o  (tx_stream.tdata),
        .rd_valid_o (tx_stream.tvalid),
        .rd_ready_i (tx_stream.tready)
    );

    uart_tx tx_serializer (
        .uart_tx_o (uart_tx_o),
        .s_axis_if (tx_stream.sink)
    );

    ////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////

    uart_rx rx_deserializer (
        .uart_rx_i (uart_rx_i),
        .m_axis_if (rx_stream.source),
        .overrun_o (out_overrun_o)
    );

    stream_fifo #(.WIDTH(uart_pkg::DATA_BITS + 1)) rx_fifo (
        .s_axis     (s_axis),
        .reset_i    (reset_i),
        .wr_data_i  (rx_stream.tdata),
        .wr_valid_i (rx_stream.tvalid),
        .wr_ready_o (rx_stream.tready),
        .rd_data_o  (rx_word),
        .rd_valid_o (out_tvalid_o),
        .rd_ready_i (out_tready_i)
    );

    // Top bit of the stored word is the frame error
    assign out_frame_err_o = rx_word[uart_pkg::DATA_BITS];
    assign out_tdata_o     = rx_word[uart_pkg::DATA_BITS-1:0];

endmodule

`default_nettype wire

// ==== bench/uart_stream_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_stream_tb;

    logic                           s_axis;
    logic                           reset_i;
    logic [uart_pkg::DATA_BITS-1:0] in_tdata_i;
    logic                           in_tvalid_i;
    logic                           in_tready_o;
    logic                           uart_tx_o;
    logic                           uart_rx_i;
    logic [uart_pkg::DATA_BITS-1:0] out_tdata_o;
    logic                           out_frame_err_o;
    logic                           out_tvalid_o;
    logic                           out_tready_i;
    logic                           out_overrun_o;

    logic loop_en;
    logic raw_line;
    logic hold_rx;
    logic saw_full;
    logic items_loaded;

    byte                            cmd_q[$];
    logic [uart_pkg::DATA_BITS-1:0] arg_q[$];
    logic [uart_pkg::DATA_BITS-1:0] tx_exp[$];
    logic [uart_pkg::DATA_BITS:0]   rx_exp[$];

    int tx_sent;
    int tx_frames;
    int drops;

    uart_stream_top uart_stream_top_i (
        .s_axis          (s_axis),
        .reset_i         (reset_i),
        .in_tdata_i      (in_tdata_i),
        .in_tvalid_i     (in_tvalid_i),
        .in_tready_o     (in_tready_o),
        .uart_tx_o       (uart_tx_o),
        .uart_rx_i       (uart_rx_i),
        .out_tdata_o     (out_tdata_o),
        .out_frame_err_o (out_frame_err_o),
        .out_tvalid_o    (out_tvalid_o),
        .out_tready_i    (out_tready_i),
        .out_overrun_o   (out_overrun_o)
    );

    // Serial loopback, cut while raw frames are driven
    assign uart_rx_i = loop_en ? uart_tx_o : raw_line;

    always #20 s_axis = ~s_axis;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic read_items();
        int                             fd;
        int                             n;
        string                          line;
        string                          cmd_s;
        logic [uart_pkg::DATA_BITS-1:0] val;
        fd = $fopen("bench/uart_stream_input.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file bench/uart_stream_input.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h", cmd_s, val);
                assert (n == 2) else begin
                    $display("stimulus line could not be read: %s", line);
                    stop_run();
                end
                cmd_q.push_back(cmd_s.getc(0));
                arg_q.push_back(val);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_tx_idle();
        @(posedge s_axis);
        while (tx_frames != tx_sent) @(posedge s_axis);
        // Let the receiver finish its stop sample
        repeat (uart_pkg::CLKS_PER_BIT) @(negedge s_axis);
    endtask

    task automatic wait_rx_drained();
        @(posedge s_axis);
        while (rx_exp.size() != 0) @(posedge s_axis);
        @(negedge s_axis);
    endtask

    // A full receive FIFO under hold loses the word
    task automatic expect_word(input logic [uart_pkg::DATA_BITS:0] w);
        if (hold_rx && rx_exp.size() >= uart_pkg::FIFO_DEPTH) begin
            drops++;
        end else begin
            rx_exp.push_back(w);
        end
    endtask

    task automatic push_byte(input logic [uart_pkg::DATA_BITS-1:0] b);
        in_tdata_i  = b;
        in_tvalid_i = 1'b1;
        while (!in_tready_o) begin
            saw_full = 1'b1;
            @(negedge s_axis);
        end
        @(negedge s_axis);
        in_tvalid_i = 1'b0;
        tx_exp.push_back(b);
        tx_sent++;
    endtask

    task automatic send_byte(input logic [uart_pkg::DATA_BITS-1:0] b);
        push_byte(b);
        expect_word({1'b0, b});
    endtask

    task automatic send_raw_frame(input logic [uart_pkg::DATA_BITS-1:0] b);
        logic [uart_pkg::DATA_BITS+1:0] bits;
        bits = {1'b0, b, 1'b0};
        wait_tx_idle();
        expect_word({1'b1, b});
        loop_en = 1'b0;
        for (int i = 0; i < uart_pkg::DATA_BITS + 2; i++) begin
            raw_line = bits[i];
            repeat (uart_pkg::CLKS_PER_BIT) @(negedge s_axis);
        end
        raw_line = 1'b1;
        repeat (uart_pkg::CLKS_PER_BIT + uart_pkg::HALF_BIT) @(negedge s_axis);
        loop_en = 1'b1;
    endtask

    task automatic start_hold();
        wait_tx_idle();
        wait_rx_drained();
        @(posedge s_axis);
        hold_rx = 1'b1;
        @(negedge s_axis);
        saw_full = 1'b0;
    endtask

    task automatic release_hold();
        wait_tx_idle();
        assert (saw_full) else begin
            $display("in_tready_o never went low during the held burst");
            stop_run();
        end
        assert (out_overrun_o === (drops != 0)) else begin
            $display("error: out_overrun_o expected %h got %h", drops != 0, out_overrun_o);
            stop_run();
        end
        @(posedge s_axis);
        hold_rx = 1'b0;
        @(negedge s_axis);
        wait_rx_drained();
    endtask

    task automatic check_reset_state();
        assert (uart_tx_o === 1'b1) else begin
            $display("error: uart_tx_o expected 1 got %h", uart_tx_o);
            stop_run();
        end
        assert (in_tready_o === 1'b1) else begin
            $display("error: in_tready_o expected 1 got %h", in_tready_o);
            stop_run();
        end
        assert (out_tvalid_o === 1'b0) else begin
            $display("error: out_tvalid_o expected 0 got %h", out_tvalid_o);
            stop_run();
        end
        assert (out_overrun_o === 1'b0) else begin
            $display("error: out_overrun_o expected 0 got %h", out_overrun_o);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    // Decodes every frame on the transmit pin at mid-bit
    initial begin : tx_line_monitor
        logic [uart_pkg::DATA_BITS-1:0] got;
        tx_frames = 0;
        forever begin
            @(negedge s_axis);
            if (uart_tx_o === 1'b0) begin
                assert (tx_exp.size() != 0) else begin
                    $display("a frame started on uart_tx_o with no byte queued");
                    stop_run();
                end
                repeat (uart_pkg::HALF_BIT - 1) @(negedge s_axis);
                assert (uart_tx_o === 1'b0) else begin
                    $display("error: uart_tx_o start bit expected 0 got %h", uart_tx_o);
                    stop_run();
                end
                for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
                    repeat (uart_pkg::CLKS_PER_BIT) @(negedge s_axis);
                    got[i] = uart_tx_o;
                end
                repeat (uart_pkg::CLKS_PER_BIT) @(negedge s_axis);
                assert (uart_tx_o === 1'b1) else begin
                    $display("error: uart_tx_o stop bit expected 1 got %h", uart_tx_o);
                    stop_run();
                end
                assert (got === tx_exp[0]) else begin
                    $display("error: uart_tx_o byte expected %h got %h", tx_exp[0], got);
                    stop_run();
                end
                void'(tx_exp.pop_front());
                tx_frames++;
            end
        end
    end

    // Random ready on the output stream, checked against the queue model
    initial begin : output_sink
        logic [16:0]                  lfsr;
        logic [uart_pkg::DATA_BITS:0] exp_word;
        lfsr         = 17'd81138;
        out_tready_i = 1'b0;
        forever begin
            @(negedge s_axis);
            if (hold_rx) begin
                out_tready_i = 1'b0;
            end else begin
                lfsr         = lfsr_step(lfsr);
                out_tready_i = lfsr[0];
            end
            if (out_tready_i && out_tvalid_o === 1'b1) begin
                assert (rx_exp.size() != 0) else begin
                    $display("a word appeared on the output with no frame behind it");
                    stop_run();
                end
                exp_word = rx_exp.pop_front();
                assert (out_tdata_o === exp_word[uart_pkg::DATA_BITS-1:0]) else begin
                    $display("error: out_tdata_o expected %h got %h",
                             exp_word[uart_pkg::DATA_BITS-1:0], out_tdata_o);
                    stop_run();
                end
                assert (out_frame_err_o === exp_word[uart_pkg::DATA_BITS]) else begin
                    $display("error: out_frame_err_o expected %h got %h",
                             exp_word[uart_pkg::DATA_BITS], out_frame_err_o);
                    stop_run();
                end
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (items_loaded === 1'b1);
        limit_ns = cmd_q.size() * 11 * uart_pkg::CLKS_PER_BIT * 40 * 2;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        stop_run();
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : main_sequence
        s_axis       = 1'b0;
        reset_i      = 1'b1;
        in_tdata_i   = '0;
        in_tvalid_i  = 1'b0;
        loop_en      = 1'b1;
        raw_line     = 1'b1;
        hold_rx      = 1'b0;
        saw_full     = 1'b0;
        items_loaded = 1'b0;
        tx_sent      = 0;
        drops        = 0;
        read_items();
        items_loaded = 1'b1;
        repeat (2) @(negedge s_axis);
        reset_i = 1'b0;
        check_reset_state();
        for (int k = 0; k < cmd_q.size(); k++) begin
            case (cmd_q[k])
                "T": send_byte(arg_q[k]);
                "F": send_raw_frame(arg_q[k]);
                "H": begin
                    if (arg_q[k] != 0) begin
                        start_hold();
                    end else begin
                        release_hold();
                    end
                end
                default: begin
                    $display("unknown command in the stimulus file at item %0d", k);
                    stop_run();
                end
            endcase
        end
        wait_tx_idle();
        wait_rx_drained();
        // Quiet line, no stray words may show up
        repeat (2 * uart_pkg::CLKS_PER_BIT) @(negedge s_axis);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/uart_stream_input.txt ====
# command byte: T sends the byte through the loopback, F drives a raw frame with a low stop bit
# H 01 holds out_tready_i low until H 00 releases it
T 55
T a3
T 00
T ff
F 3c
F 81
T 12
H 01
T 10
T 11
T 12
T 13
T 14
T 15
T 16
T 17
T 18
T 19
T 1a
H 00
T 7e
F c5
T 42

// ==== filelist.f ====
src/uart_pkg.sv
src/axis_if.sv
src/stream_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_stream_top.sv
bench/uart_stream_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module uart_stream_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

if [ ! -x ./obj_dir/Vuart_stream_tb ]; then
    echo "Simulation binary not found"
    exit 1
fi

output=$(./obj_dir/Vuart_stream_tb 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
